// File: Makefile
SRCS := $(shell grep -v '^+' list.f)

obj_dir/Vtb_memory_game: list.f $(SRCS)
	verilator --binary --timing -j 0 --top-module tb_memory_game -f list.f

run: obj_dir/Vtb_memory_game
	./obj_dir/Vtb_memory_game | tee /dev/stderr | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

.PHONY: run clean

// File: button_pulse.sv
module button_pulse (
    input  logic clk,
    input  logic rst,
    input  logic btn_i,
    output logic pulse_o
);
    import memory_game_pkg::*;

    logic [DEBOUNCE_LEN-1:0] samples;
    logic                    debounced;
    logic                    debounced_q;

    // Stable only when every sample in the window is high
    assign debounced = &samples;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            samples <= '0;
        end else begin
            samples <= {samples[DEBOUNCE_LEN-2:0], btn_i};
        end
    end

    // Rising edge of the debounced level
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            debounced_q <= 1'b0;
            pulse_o     <= 1'b0;
        end else begin
            debounced_q <= debounced;
            pulse_o     <= debounced & ~debounced_q;
        end
    end

endmodule

// File: game_ctrl.sv
module game_ctrl (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start_i,
    input  logic                         hint_i,
    input  memory_game_pkg::move_t       move_i,
    output memory_game_pkg::tile_view_t  view_o,
    output memory_game_pkg::game_state_t state_o,
    output logic                         pass_o
);
    import memory_game_pkg::*;

    game_state_t           state;
    logic [NUM_TILES-1:0]  show_bits;
    logic [NUM_TILES-1:0]  good_bits;
    logic [NUM_TILES-1:0]  flip_bits;
    logic                  armed;
    logic [PAIR_CNT_W-1:0] pair_cnt;
    logic                  pair_match;

    // Same image, same orientation, and not already solved
    assign pair_match = (move_i.tile_a[IMG_ID_W-1:0] == move_i.tile_b[IMG_ID_W-1:0])
        && (flip_bits[move_i.tile_a] == flip_bits[move_i.tile_b])
        && !good_bits[move_i.tile_a];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= GS_INIT;
            show_bits <= '0;
            good_bits <= '0;
            flip_bits <= '0;
            armed     <= 1'b0;
            pair_cnt  <= '0;
            pass_o    <= 1'b0;
        end else begin
            case (state)
                GS_INIT: begin
                    show_bits <= '0;
                    good_bits <= '0;
                    flip_bits <= '0;
                    pair_cnt  <= '0;
                    pass_o    <= 1'b0;
                    if (start_i) begin
                        state <= GS_SHOW;
                    end
                end
                GS_SHOW: begin
                    show_bits <= '1;
                    if (start_i) begin
                        state     <= GS_GAME;
                        show_bits <= '0;
                        good_bits <= '0;
                        flip_bits <= '0;
                        pair_cnt  <= '0;
                        armed     <= 1'b1;
                    end
                end
                GS_GAME: begin
                    if (pair_cnt == PAIR_CNT_W'(WIN_PAIRS)) begin
                        state <= GS_FINISH;
                    end else if (move_i.valid && !hint_i) begin
                        case (move_i.op)
                            OP_PAIR: begin
                                if (armed) begin
                                    show_bits[move_i.tile_a] <= 1'b1;
                                    show_bits[move_i.tile_b] <= 1'b1;
                                    armed                    <= 1'b0;
                                    if (pair_match) begin
                                        good_bits[move_i.tile_a] <= 1'b1;
                                        good_bits[move_i.tile_b] <= 1'b1;
                                        pair_cnt                 <= pair_cnt + 1'b1;
                                    end
                                end
                            end
                            OP_FLIP: begin
                                if (armed) begin
                                    show_bits[move_i.tile_a] <= 1'b1;
                                    flip_bits[move_i.tile_a] <= ~flip_bits[move_i.tile_a];
                                    armed                    <= 1'b0;
                                end
                            end
                            OP_HIDE: begin
                                if (!armed) begin
                                    show_bits <= '0;
                                    armed     <= 1'b1;
                                end
                            end
                            default: begin
                            end
                        endcase
                    end
                end
                GS_FINISH: begin
                    pass_o <= 1'b1;
                    if (start_i) begin
                        state <= GS_INIT;
                    end
                end
                default: state <= GS_INIT;
            endcase
        end
    end

    // Hint in GAME reveals the whole board
    always_comb begin
        view_o.visible = (state == GS_GAME && hint_i) ? '1 : (show_bits | good_bits);
        view_o.flip    = flip_bits;
    end

    assign state_o = state;

endmodule

// File: key_tracker.sv
module key_tracker (
    input  logic                        clk,
    input  logic                        rst,
    input  memory_game_pkg::key_event_t key_i,
    output memory_game_pkg::move_t      move_o
);
    import memory_game_pkg::*;

    logic [NUM_TILES-1:0] held_tiles;
    logic                 held_shift;
    scan_code_t           prev_code;

    logic      c_hit;
    tile_idx_t c_idx;
    logic      p_hit;
    tile_idx_t p_idx;
    logic      c_shift;
    logic      p_shift;
    logic      p_held;
    move_t     next_move;

    // Tile lookup, returns {hit, index}
    function automatic logic [4:0] decode_tile(input scan_code_t code);
        logic [4:0] res;
        res = '0;
        for (int i = 0; i < NUM_TILES; i++) begin
            if (code == TILE_KEYS[i]) begin
                res = {1'b1, 4'(i)};
            end
        end
        return res;
    endfunction

    always_comb begin
        {c_hit, c_idx} = decode_tile(key_i.code);
        {p_hit, p_idx} = decode_tile(prev_code);
        c_shift = (key_i.code == KEY_SHIFT);
        p_shift = (prev_code == KEY_SHIFT);
        p_held  = (p_hit && held_tiles[p_idx]) || (p_shift && held_shift);

        next_move = '0;
        if (key_i.strobe && !key_i.released) begin
            if (key_i.code == KEY_ENTER) begin
                next_move.valid = 1'b1;
                next_move.op    = OP_HIDE;
            end else if (p_held && prev_code != key_i.code) begin
                if (c_shift && p_hit) begin
                    next_move.valid  = 1'b1;
                    next_move.op     = OP_FLIP;
                    next_move.tile_a = p_idx;
                end else if (p_shift && c_hit) begin
                    next_move.valid  = 1'b1;
                    next_move.op     = OP_FLIP;
                    next_move.tile_a = c_idx;
                end else if (c_hit && p_hit) begin
                    next_move.valid  = 1'b1;
                    next_move.op     = OP_PAIR;
                    next_move.tile_a = c_idx;
                    next_move.tile_b = p_idx;
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            held_tiles <= '0;
            held_shift <= 1'b0;
            prev_code  <= '0;
            move_o     <= '0;
        end else begin
            if (key_i.strobe) begin
                if (c_hit) begin
                    held_tiles[c_idx] <= !key_i.released;
                end
                if (c_shift) begin
                    held_shift <= !key_i.released;
                end
                if (!key_i.released) begin
                    prev_code <= key_i.code;
                end
            end
            move_o <= next_move;
        end
    end

endmodule

// File: list.f
memory_game_pkg.sv
button_pulse.sv
key_tracker.sv
game_ctrl.sv
vga_timing.sv
tile_renderer.sv
memory_game_top.sv
tb_memory_game.sv

// File: memory_game_pkg.sv
package memory_game_pkg;

    // Board and image geometry
    localparam int NUM_TILES  = 16;
    localparam int NUM_IMAGES = 8;
    localparam int IMG_ID_W   = $clog2(NUM_IMAGES);
    localparam int TILE_W     = 80;
    localparam int TILE_H     = 60;
    localparam int PIX_ADDR_W = 13;
    localparam int RGB_W      = 12;

    // 640x480 raster, one pixel per clk
    localparam int CNT_W    = 10;
    localparam int H_ACTIVE = 640;
    localparam int H_FRONT  = 16;
    localparam int H_SYNC   = 96;
    localparam int H_BACK   = 48;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 33;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    localparam int DEBOUNCE_LEN = 7;
    localparam int WIN_PAIRS    = 8;
    localparam int PAIR_CNT_W   = $clog2(WIN_PAIRS + 1);

    typedef logic [7:0] scan_code_t;

    localparam scan_code_t KEY_SHIFT = 8'h12;
    localparam scan_code_t KEY_ENTER = 8'h5A;

    // Row by row: 1-4, Q-R, A-F, Z-V
    localparam scan_code_t TILE_KEYS [NUM_TILES] = '{
        8'h16, 8'h1E, 8'h26, 8'h25,
        8'h15, 8'h1D, 8'h24, 8'h2D,
        8'h1C, 8'h1B, 8'h23, 8'h2B,
        8'h1A, 8'h22, 8'h21, 8'h2A
    };

    typedef logic [3:0] tile_idx_t;

    typedef enum logic [1:0] {
        GS_INIT,
        GS_SHOW,
        GS_GAME,
        GS_FINISH
    } game_state_t;

    typedef enum logic [1:0] {
        OP_PAIR,
        OP_FLIP,
        OP_HIDE
    } move_op_t;

    typedef struct packed {
        logic       strobe;
        logic       released;
        scan_code_t code;
    } key_event_t;

    typedef struct packed {
        logic      valid;
        move_op_t  op;
        tile_idx_t tile_a;
        tile_idx_t tile_b;
    } move_t;

    typedef struct packed {
        logic [CNT_W-1:0] h_cnt;
        logic [CNT_W-1:0] v_cnt;
        logic             active;
    } raster_t;

    typedef struct packed {
        logic [NUM_TILES-1:0] visible;
        logic [NUM_TILES-1:0] flip;
    } tile_view_t;

endpackage

// File: memory_game_top.sv
module memory_game_top (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     start_i,
    input  logic                                     hint_i,
    input  memory_game_pkg::key_event_t              key_i,
    input  logic [memory_game_pkg::RGB_W-1:0]        pixel_i,
    output logic [memory_game_pkg::IMG_ID_W-1:0]     img_id_o,
    output logic [memory_game_pkg::PIX_ADDR_W-1:0]   pix_addr_o,
    output logic [memory_game_pkg::RGB_W-1:0]        rgb_o,
    output logic                                     hsync_o,
    output logic                                     vsync_o,
    output memory_game_pkg::game_state_t             state_o,
    output logic                                     pass_o
);
    import memory_game_pkg::*;

    logic       start_pulse;
    move_t      move;
    tile_view_t view;
    raster_t    raster;

    button_pulse i_start_btn (
        .clk    (clk),
        .rst    (rst),
        .btn_i  (start_i),
        .pulse_o(start_pulse)
    );

    key_tracker i_keys (
        .clk   (clk),
        .rst   (rst),
        .key_i (key_i),
        .move_o(move)
    );

    game_ctrl i_ctrl (
        .clk    (clk),
        .rst    (rst),
        .start_i(start_pulse),
        .hint_i (hint_i),
        .move_i (move),
        .view_o (view),
        .state_o(state_o),
        .pass_o (pass_o)
    );

    vga_timing i_vga (
        .clk     (clk),
        .rst     (rst),
        .raster_o(raster),
        .hsync_o (hsync_o),
        .vsync_o (vsync_o)
    );

    tile_renderer i_render (
        .raster_i  (raster),
        .view_i    (view),
        .img_id_o  (img_id_o),
        .pix_addr_o(pix_addr_o),
        .pixel_i   (pixel_i),
        .rgb_o     (rgb_o)
    );

endmodule

// File: tb_memory_game.sv
module tb_memory_game;
    import memory_game_pkg::*;

    logic                  clk;
    logic                  rst;
    logic                  start;
    logic                  hint;
    key_event_t            key;
    logic [RGB_W-1:0]      pixel;
    logic [IMG_ID_W-1:0]   img_id;
    logic [PIX_ADDR_W-1:0] pix_addr;
    logic [RGB_W-1:0]      rgb;
    logic                  hsync;
    logic                  vsync;
    game_state_t           state;
    logic                  pass_flag;

    // Reference model of the game
    game_state_t          m_state;
    logic [NUM_TILES-1:0] m_show;
    logic [NUM_TILES-1:0] m_good;
    logic [NUM_TILES-1:0] m_flip;
    logic                 m_armed;
    logic                 m_hint;
    int                   m_pairs;

    int   h_ref;
    int   v_ref;
    logic check_en;
    int   errors;

    memory_game_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .start_i   (start),
        .hint_i    (hint),
        .key_i     (key),
        .pixel_i   (pixel),
        .img_id_o  (img_id),
        .pix_addr_o(pix_addr),
        .rgb_o     (rgb),
        .hsync_o   (hsync),
        .vsync_o   (vsync),
        .state_o   (state),
        .pass_o    (pass_flag)
    );

    // Image memory stand-in with the id on top
    function automatic logic [RGB_W-1:0] img_pixel(input logic [IMG_ID_W-1:0] id,
                                                    input logic [PIX_ADDR_W-1:0] addr);
        return {id, addr[8:0] ^ {5'b0, addr[12:9]}};
    endfunction

    function automatic logic [RGB_W-1:0] expected_rgb(input int h, input int v);
        int   x;
        int   y;
        int   tile;
        int   py;
        int   addr;
        logic vis;
        if (h >= H_ACTIVE || v >= V_ACTIVE) begin
            return '0;
        end
        x = h / 2;
        y = v / 2;
        tile = (y / TILE_H) * 4 + x / TILE_W;
        vis = m_show[tile] || m_good[tile] || (m_state == GS_GAME && m_hint);
        if (!vis) begin
            return '0;
        end
        py = m_flip[tile] ? TILE_H - 1 - y % TILE_H : y % TILE_H;
        addr = x % TILE_W + py * TILE_W;
        return img_pixel(IMG_ID_W'(tile % NUM_IMAGES), PIX_ADDR_W'(addr));
    endfunction

    function automatic logic sync_level(input logic use_v);
        return use_v ? vsync : hsync;
    endfunction

    assign pixel = img_pixel(img_id, pix_addr);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Raster position held at 0 during reset
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            h_ref <= 0;
            v_ref <= 0;
        end else if (h_ref == H_TOTAL - 1) begin
            h_ref <= 0;
            v_ref <= (v_ref == V_TOTAL - 1) ? 0 : v_ref + 1;
        end else begin
            h_ref <= h_ref + 1;
        end
    end

    always @(negedge clk) begin
        if (check_en) begin
            check_value("rgb_o pixel", 32'(rgb), 32'(expected_rgb(h_ref, v_ref)));
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic end_run();
        $display("Run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    task automatic wait_for_state(input game_state_t s, input int limit);
        int n;
        n = 0;
        while (state != s) begin
            @(negedge clk);
            n++;
            if (n > limit) begin
                $display("Timeout: state did not reach %0d within %0d cycles", s, limit);
                errors++;
                end_run();
            end
        end
    endtask

    task automatic wait_for_pass(input logic level, input int limit);
        int n;
        n = 0;
        while (pass_flag !== level) begin
            @(negedge clk);
            n++;
            if (n > limit) begin
                $display("Timeout: pass_o did not become %0b within %0d cycles", level, limit);
                errors++;
                end_run();
            end
        end
    endtask

    task automatic wait_for_sync(input logic use_v, input logic level, input int limit,
                                 output int cycles);
        cycles = 0;
        while (sync_level(use_v) !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                $display("Timeout: sync (vertical %0b) stuck away from %0b", use_v, level);
                errors++;
                end_run();
            end
        end
    endtask

    task automatic measure_sync(input logic use_v, input int limit,
                                output int low_w, output int period);
        int skip;
        int high_w;
        wait_for_sync(use_v, 1'b1, limit, skip);
        wait_for_sync(use_v, 1'b0, limit, skip);
        wait_for_sync(use_v, 1'b1, limit, low_w);
        wait_for_sync(use_v, 1'b0, limit, high_w);
        period = low_w + high_w;
    endtask

    task automatic check_frame();
        @(posedge clk);
        check_en = 1'b1;
        repeat (H_TOTAL * V_TOTAL) @(posedge clk);
        check_en = 1'b0;
        @(negedge clk);
    endtask

    // Model of the move rules
    task automatic apply_move(input move_op_t op, input int a, input int b);
        if (m_state == GS_GAME && !m_hint) begin
            case (op)
                OP_PAIR: begin
                    if (m_armed) begin
                        m_show[a] = 1'b1;
                        m_show[b] = 1'b1;
                        m_armed = 1'b0;
                        if (a % 8 == b % 8 && m_flip[a] == m_flip[b] && !m_good[a]) begin
                            m_good[a] = 1'b1;
                            m_good[b] = 1'b1;
                            m_pairs++;
                        end
                    end
                end
                OP_FLIP: begin
                    if (m_armed) begin
                        m_show[a] = 1'b1;
                        m_flip[a] = ~m_flip[a];
                        m_armed = 1'b0;
                    end
                end
                default: begin
                    if (!m_armed) begin
                        m_show = '0;
                        m_armed = 1'b1;
                    end
                end
            endcase
            if (m_pairs == WIN_PAIRS) begin
                m_state = GS_FINISH;
            end
        end
    endtask

    // Key event plus the two edges until the move lands
    task automatic send_key(input scan_code_t code, input logic rel);
        key.strobe = 1'b1;
        key.released = rel;
        key.code = code;
        @(negedge clk);
        key.strobe = 1'b0;
        @(negedge clk);
        @(negedge clk);
    endtask

    task automatic press_pair(input int a, input int b);
        send_key(TILE_KEYS[a], 1'b0);
        send_key(TILE_KEYS[b], 1'b0);
        apply_move(OP_PAIR, b, a);
        send_key(TILE_KEYS[b], 1'b1);
        send_key(TILE_KEYS[a], 1'b1);
    endtask

    task automatic press_flip(input int t);
        send_key(KEY_SHIFT, 1'b0);
        send_key(TILE_KEYS[t], 1'b0);
        apply_move(OP_FLIP, t, 0);
        send_key(TILE_KEYS[t], 1'b1);
        send_key(KEY_SHIFT, 1'b1);
    endtask

    task automatic press_enter();
        send_key(KEY_ENTER, 1'b0);
        apply_move(OP_HIDE, 0, 0);
        send_key(KEY_ENTER, 1'b1);
    endtask

    task automatic advance_start(input game_state_t next);
        start = 1'b1;
        wait_for_state(next, 4 * DEBOUNCE_LEN);
        start = 1'b0;
        @(negedge clk);
        @(negedge clk);
        m_state = next;
        m_show = (next == GS_SHOW) ? '1 : '0;
        m_good = '0;
        m_flip = '0;
        m_pairs = 0;
        if (next == GS_GAME) begin
            m_armed = 1'b1;
        end
        check_value("state_o", 32'(state), 32'(m_state));
    endtask

    initial begin
        int a;
        int b;
        int t;
        int low_w;
        int period;
        void'($urandom(12));
        rst = 1'b1;
        start = 1'b0;
        hint = 1'b0;
        key = '0;
        check_en = 1'b0;
        errors = 0;
        m_state = GS_INIT;
        m_show = '0;
        m_good = '0;
        m_flip = '0;
        m_armed = 1'b0;
        m_hint = 1'b0;
        m_pairs = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        check_value("state_o after reset", 32'(state), 32'(GS_INIT));
        check_value("pass_o after reset", 32'(pass_flag), 0);
        check_value("hsync_o after reset", 32'(hsync), 1);
        check_value("vsync_o after reset", 32'(vsync), 1);

        // Press too short for the debouncer
        start = 1'b1;
        repeat (DEBOUNCE_LEN - 1) @(negedge clk);
        start = 1'b0;
        repeat (2 * DEBOUNCE_LEN) @(negedge clk);
        check_value("state_o after short press", 32'(state), 32'(GS_INIT));

        advance_start(GS_SHOW);
        check_frame();

        measure_sync(1'b0, 2 * H_TOTAL, low_w, period);
        check_value("hsync low width", 32'(low_w), 32'(H_SYNC));
        check_value("hsync period", 32'(period), 32'(H_TOTAL));
        measure_sync(1'b1, 2 * H_TOTAL * V_TOTAL, low_w, period);
        check_value("vsync low width", 32'(low_w), 32'(V_SYNC * H_TOTAL));
        check_value("vsync period", 32'(period), 32'(V_TOTAL * H_TOTAL));

        advance_start(GS_GAME);

        // Wrong pair followed by a second pair while disarmed
        a = int'($urandom % 16);
        b = (a + 1 + int'($urandom % 7)) % 16;
        press_pair(a, b);
        a = int'($urandom % 16);
        b = (a + 1 + int'($urandom % 7)) % 16;
        press_pair(a, b);
        check_frame();
        press_enter();
        check_frame();

        // Flip one half of a pair
        t = int'($urandom % 8);
        press_flip(t);
        check_frame();
        press_enter();
        press_pair(t, t + 8);
        press_enter();
        check_frame();
        press_flip(t + 8);
        press_enter();
        press_pair(t, t + 8);
        press_enter();

        hint = 1'b1;
        m_hint = 1'b1;
        check_frame();
        press_pair((t + 1) % 8, (t + 1) % 8 + 8);
        hint = 1'b0;
        m_hint = 1'b0;
        check_frame();

        for (int i = 0; i < 8; i++) begin
            if (!m_good[i]) begin
                press_pair(i, i + 8);
                check_value("state_o after pair", 32'(state), 32'(m_state));
                if (m_state == GS_GAME) begin
                    press_enter();
                end
            end
        end
        wait_for_pass(1'b1, 20);

        advance_start(GS_INIT);
        wait_for_pass(1'b0, 20);

        end_run();
    end

endmodule

// File: tile_renderer.sv
module tile_renderer (
    input  memory_game_pkg::raster_t                  raster_i,
    input  memory_game_pkg::tile_view_t               view_i,
    output logic [memory_game_pkg::IMG_ID_W-1:0]      img_id_o,
    output logic [memory_game_pkg::PIX_ADDR_W-1:0]    pix_addr_o,
    input  logic [memory_game_pkg::RGB_W-1:0]         pixel_i,
    output logic [memory_game_pkg::RGB_W-1:0]         rgb_o
);
    import memory_game_pkg::*;

    logic [CNT_W-2:0] x;
    logic [CNT_W-2:0] y;
    logic [1:0]       col;
    logic [1:0]       row;
    tile_idx_t        tile;
    logic [6:0]       px;
    logic [6:0]       py_raw;
    logic [6:0]       py;

    always_comb begin
        // Each image pixel covers 2x2 screen pixels
        x = raster_i.h_cnt[CNT_W-1:1];
        y = raster_i.v_cnt[CNT_W-1:1];

        col  = 2'(x / TILE_W);
        row  = 2'(y / TILE_H);
        tile = {row, col};

        px     = 7'(x % TILE_W);
        py_raw = 7'(y % TILE_H);
        // Vertical mirror
        py = view_i.flip[tile] ? 7'(TILE_H - 1) - py_raw : py_raw;
    end

    assign img_id_o   = tile[IMG_ID_W-1:0];
    assign pix_addr_o = PIX_ADDR_W'(px + py * TILE_W);

    assign rgb_o = (raster_i.active && view_i.visible[tile]) ? pixel_i : '0;

endmodule

// File: vga_timing.sv
module vga_timing (
    input  logic                     clk,
    input  logic                     rst,
    output memory_game_pkg::raster_t raster_o,
    output logic                     hsync_o,
    output logic                     vsync_o
);
    import memory_game_pkg::*;

    logic [CNT_W-1:0] pixel_cnt;
    logic [CNT_W-1:0] line_cnt;
    logic             h_active;
    logic             v_active;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pixel_cnt <= '0;
            line_cnt  <= '0;
        end else if (pixel_cnt == CNT_W'(H_TOTAL - 1)) begin
            pixel_cnt <= '0;
            if (line_cnt == CNT_W'(V_TOTAL - 1)) begin
                line_cnt <= '0;
            end else begin
                line_cnt <= line_cnt + 1'b1;
            end
        end else begin
            pixel_cnt <= pixel_cnt + 1'b1;
        end
    end

    // Sync goes low one count early since it is registered
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hsync_o <= 1'b1;
            vsync_o <= 1'b1;
        end else begin
            hsync_o <= !((pixel_cnt >= CNT_W'(H_ACTIVE + H_FRONT - 1))
                && (pixel_cnt < CNT_W'(H_ACTIVE + H_FRONT + H_SYNC - 1)));
            vsync_o <= !((line_cnt >= CNT_W'(V_ACTIVE + V_FRONT - 1))
                && (line_cnt < CNT_W'(V_ACTIVE + V_FRONT + V_SYNC - 1)));
        end
    end

    assign h_active = (pixel_cnt < CNT_W'(H_ACTIVE));
    assign v_active = (line_cnt < CNT_W'(V_ACTIVE));

    always_comb begin
        raster_o.h_cnt  = h_active ? pixel_cnt : '0;
        raster_o.v_cnt  = v_active ? line_cnt : '0;
        raster_o.active = h_active && v_active;
    end

endmodule
